//--- design/gmii_tx_settings.svh
/* GMII transmit constants. The word layout must add up to GMII_WORD_WIDTH.
   Queue depth also sets the upstream side's starting credit count. */
`ifndef GMII_TX_SETTINGS_SVH
`define GMII_TX_SETTINGS_SVH

// packet word layout, MSB first
`define GMII_WORD_BYTES    16
`define GMII_WORD_WIDTH    139
`define GMII_KIND_W        3
`define GMII_LAST_W        4
`define GMII_DATA_W        (`GMII_WORD_BYTES * 8)
`define GMII_RSVD_W        (`GMII_WORD_WIDTH - `GMII_KIND_W - `GMII_LAST_W - `GMII_DATA_W)

`define GMII_WORD_DEPTH    256           // entries per queue

// framing
`define GMII_IFG_CYCLES    12            // idle cycles between frames
`define GMII_PREAMBLE_LEN  7             // count of 0x55 bytes
`define GMII_PREAMBLE_BYTE 8'h55
`define GMII_SFD_BYTE      8'hD5

`endif

//--- design/gmii_tx_pkg.sv
/* Types shared by the GMII transmit path. Payload is sent most significant byte
   first; last_idx only has meaning in a tail word. */
`default_nettype none

`include "gmii_tx_settings.svh"

package gmii_tx_pkg;

  // word kind codes, as the packet engine writes them
  typedef enum logic [`GMII_KIND_W-1:0] {
    WORD_MID  = 3'b100,
    WORD_HEAD = 3'b101,
    WORD_TAIL = 3'b110
  } word_kind_t;

  typedef struct packed {
    word_kind_t               kind;
    logic [`GMII_LAST_W-1:0]  last_idx;  // last valid byte of a tail word
    logic [`GMII_RSVD_W-1:0]  rsvd;      // pads the word to 139 bits
    logic [`GMII_DATA_W-1:0]  data;      // byte 0 in the top bits
  } pkt_word_t;

  // one byte lane of the GMII transmit side
  typedef struct packed {
    logic [7:0] txd;
    logic       txen;
  } gmii_tx_t;

endpackage

`default_nettype wire

//--- design/pkt_sync_fifo.sv
/* Show-ahead synchronous queue; pop_data is valid whenever empty is low.
   Pushing into a full queue is a protocol error and is not blocked here. */
`timescale 1ns/1ps
`default_nettype none

module pkt_sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
) (
  input  logic     gmii_txclk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_pop;

  assign empty    = (count == '0);
  assign full     = (count == CW'(DEPTH));
  assign do_pop   = pop && !empty;   // popping an empty queue is ignored
  assign pop_data = mem[rd_ptr];     // oldest entry with no read latency

  // entry storage
  always_ff @(posedge gmii_txclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge gmii_txclk or negedge reset)
  begin
    if (!reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        if (wr_ptr == AW'(DEPTH - 1))   // depth need not be a power of two
          wr_ptr <= '0;
        else
          wr_ptr <= wr_ptr + 1'b1;
      end

      if (do_pop)
      begin
        if (rd_ptr == AW'(DEPTH - 1))
          rd_ptr <= '0;
        else
          rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/frame_serializer.sv
/* Turns queued packet words into GMII bytes: gap, preamble, SFD, then payload.
   All words of a packet must be queued before its verdict becomes visible. */
`timescale 1ns/1ps
`default_nettype none

`include "gmii_tx_settings.svh"

module frame_serializer (
  input  logic                   gmii_txclk,
  input  logic                   reset,
  input  gmii_tx_pkg::pkt_word_t word,
  input  logic                   word_empty,
  output logic                   word_pop,
  input  logic                   verdict_ok,
  input  logic                   verdict_empty,
  output logic                   verdict_pop,
  output gmii_tx_pkg::gmii_tx_t  gmii,
  output logic                   port_send
);

  import gmii_tx_pkg::*;

  localparam int GAP_W = $clog2(`GMII_IFG_CYCLES + 1);
  localparam int PRE_W = $clog2(`GMII_PREAMBLE_LEN + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREAMBLE,
    ST_PAYLOAD,
    ST_DISCARD
  } state_t;

  state_t                  state;
  logic [GAP_W-1:0]        gap_cnt;
  logic [PRE_W-1:0]        pre_cnt;
  logic [`GMII_LAST_W-1:0] byte_idx;   // byte of hold now on the wire
  pkt_word_t               hold;       // word being serialized
  logic [7:0]              txd_q;
  logic                    txen_q;

  logic                    gap_done;
  logic                    accept;
  logic                    head_ok;
  logic                    sfd_now;
  logic                    word_end;
  logic                    word_last;
  logic [7:0]              cur_byte;

  assign gap_done  = (gap_cnt == GAP_W'(`GMII_IFG_CYCLES));
  assign accept    = (state == ST_IDLE) && gap_done && !word_empty && !verdict_empty;
  assign head_ok   = (word.kind == WORD_HEAD);
  assign sfd_now   = (pre_cnt == PRE_W'(`GMII_PREAMBLE_LEN));
  assign word_end  = (byte_idx == `GMII_LAST_W'(`GMII_WORD_BYTES - 1));
  assign word_last = (hold.kind == WORD_TAIL) && (byte_idx == hold.last_idx);
  assign cur_byte  = hold.data[(`GMII_WORD_BYTES - 1 - byte_idx) * 8 +: 8];   // MSB first

  assign gmii.txd  = txd_q;
  assign gmii.txen = txen_q;

  // pops act at the coming edge, so queue heads are always current
  always_comb
  begin
    verdict_pop = accept;
    word_pop    = 1'b0;
    case (state)
      ST_IDLE:    word_pop = accept && head_ok;   // head goes into hold
      ST_PAYLOAD: word_pop = word_end && (hold.kind != WORD_TAIL);
      ST_DISCARD: word_pop = !word_empty;
      default:    word_pop = 1'b0;
    endcase
  end

  // held word and output byte
  always_ff @(posedge gmii_txclk)
  begin
    if (word_pop)
    begin
      hold <= word;
    end

    case (state)
      ST_PREAMBLE: txd_q <= sfd_now ? `GMII_SFD_BYTE : `GMII_PREAMBLE_BYTE;
      ST_PAYLOAD:  txd_q <= cur_byte;
      default:     txd_q <= 8'h00;   // quiet bus between frames
    endcase
  end

  always_ff @(posedge gmii_txclk or negedge reset)
  begin
    if (!reset)
    begin
      state     <= ST_IDLE;
      gap_cnt   <= '0;
      pre_cnt   <= '0;
      byte_idx  <= '0;
      txen_q    <= 1'b0;
      port_send <= 1'b0;
    end
    else
    begin
      port_send <= 1'b0;   // single-cycle pulse

      case (state)
        ST_IDLE:
        begin
          txen_q <= 1'b0;
          if (!gap_done)
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
          else if (accept)
          begin
            gap_cnt <= '0;
            if (verdict_ok && head_ok)
            begin
              port_send <= 1'b1;
              pre_cnt   <= '0;
              state     <= ST_PREAMBLE;
            end
            else
            begin
              state <= ST_DISCARD;   // bad verdict or no head word
            end
          end
        end

        ST_PREAMBLE:
        begin
          txen_q <= 1'b1;
          if (sfd_now)
          begin
            pre_cnt  <= '0;
            byte_idx <= '0;
            state    <= ST_PAYLOAD;
          end
          else
          begin
            pre_cnt <= pre_cnt + 1'b1;
          end
        end

        ST_PAYLOAD:
        begin
          txen_q <= 1'b1;
          if (word_last)
          begin
            gap_cnt <= '0;
            state   <= ST_IDLE;
          end
          else if (word_end)
          begin
            byte_idx <= '0;   // next word loads into hold
          end
          else
          begin
            byte_idx <= byte_idx + 1'b1;
          end
        end

        ST_DISCARD:
        begin
          txen_q <= 1'b0;
          if (word_pop && (word.kind == WORD_TAIL))
          begin
            gap_cnt <= '0;   // dropped packet costs a gap too
            state   <= ST_IDLE;
          end
        end

        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/gmii_tx_top.sv
/* Single-clock GMII transmit path. Upstream pushes words only while it holds
   credits, and writes a packet's verdict after that packet's tail word. */
`timescale 1ns/1ps
`default_nettype none

`include "gmii_tx_settings.svh"

module gmii_tx_top (
  input  logic                   gmii_txclk,
  input  logic                   reset,
  input  logic                   word_push,
  input  gmii_tx_pkg::pkt_word_t word_in,
  input  logic                   verdict_push,
  input  logic                   verdict_ok,
  output logic                   credit_return,
  output gmii_tx_pkg::gmii_tx_t  gmii,
  output logic                   port_send
);

  import gmii_tx_pkg::*;

  pkt_word_t word_q;
  logic      word_empty;
  logic      word_full;      // watched by the protocol checks
  logic      word_pop;
  logic      verdict_q;
  logic      verdict_empty;
  logic      verdict_full;   // no credits of its own
  logic      verdict_pop;

  assign credit_return = word_pop;   // one credit back per word popped

  pkt_sync_fifo #(
    .payload_t (pkt_word_t),
    .DEPTH     (`GMII_WORD_DEPTH)
  ) u_word_q (
    .gmii_txclk (gmii_txclk),
    .reset      (reset),
    .push       (word_push),
    .push_data  (word_in),
    .pop        (word_pop),
    .pop_data   (word_q),
    .empty      (word_empty),
    .full       (word_full)
  );

  // one entry per packet, same depth as the word queue
  pkt_sync_fifo #(
    .payload_t (logic),
    .DEPTH     (`GMII_WORD_DEPTH)
  ) u_verdict_q (
    .gmii_txclk (gmii_txclk),
    .reset      (reset),
    .push       (verdict_push),
    .push_data  (verdict_ok),
    .pop        (verdict_pop),
    .pop_data   (verdict_q),
    .empty      (verdict_empty),
    .full       (verdict_full)
  );

  frame_serializer u_serializer (
    .gmii_txclk    (gmii_txclk),
    .reset         (reset),
    .word          (word_q),
    .word_empty    (word_empty),
    .word_pop      (word_pop),
    .verdict_ok    (verdict_q),
    .verdict_empty (verdict_empty),
    .verdict_pop   (verdict_pop),
    .gmii          (gmii),
    .port_send     (port_send)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
/* Testbench clock and reset. 10 ns gmii_txclk; reset is held low for the
   first 10 rising edges and released on an edge. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic gmii_txclk,
  output logic reset
);

  initial
  begin
    gmii_txclk = 1'b0;
    forever #5 gmii_txclk = ~gmii_txclk;   // 100 MHz stand-in for 125
  end

  initial
  begin
    reset = 1'b0;
    repeat (10) @(posedge gmii_txclk);
    reset <= 1'b1;
  end

endmodule

`default_nettype wire

//--- test/gmii_tx_asserts.sv
/* Protocol checks bound into gmii_tx_top. Queue overflow is only caught here,
   since the queues themselves do not block a push when full. */
`timescale 1ns/1ps
`default_nettype none

module gmii_tx_asserts (
  input logic gmii_txclk,
  input logic reset,
  input logic word_push,
  input logic word_full,
  input logic verdict_push,
  input logic verdict_full,
  input logic port_send,
  input logic txen
);

  int fail_count = 0;   // failed assertions so far

  no_word_overflow: assert property (@(posedge gmii_txclk) disable iff (!reset)
    word_push |-> !word_full)
  else
  begin
    fail_count++;
    $error("word queue pushed while full");
  end

  no_verdict_overflow: assert property (@(posedge gmii_txclk) disable iff (!reset)
    verdict_push |-> !verdict_full)
  else
  begin
    fail_count++;
    $error("verdict queue pushed while full");
  end

  // frame start ordering
  send_then_txen: assert property (@(posedge gmii_txclk) disable iff (!reset)
    port_send |=> txen)
  else
  begin
    fail_count++;
    $error("port_send not followed by txen");
  end

  txen_needs_send: assert property (@(posedge gmii_txclk) disable iff (!reset)
    $rose(txen) |-> $past(port_send))
  else
  begin
    fail_count++;
    $error("txen rose without port_send one cycle before");
  end

endmodule

bind gmii_tx_top gmii_tx_asserts u_asserts (
  .gmii_txclk   (gmii_txclk),
  .reset        (reset),
  .word_push    (word_push),
  .word_full    (word_full),
  .verdict_push (verdict_push),
  .verdict_full (verdict_full),
  .port_send    (port_send),
  .txen         (gmii.txen)
);

`default_nettype wire

//--- test/gmii_tx_tb.sv
/* Random GMII transmit traffic against a byte-level frame model.
   Upstream credits start at GMII_WORD_DEPTH; verdicts follow each tail word. */
`timescale 1ns/1ps
`default_nettype none

`include "gmii_tx_settings.svh"

module gmii_tx_tb;

  import gmii_tx_pkg::*;

  localparam int NUM_RANDOM = 80;
  localparam int MAX_WORDS  = 2 + 10 + NUM_RANDOM * 5;        // every test's words
  localparam int TIMEOUT_NS = 4 * MAX_WORDS * 16 * 10 + 5000;

  logic gmii_txclk, reset, word_push, verdict_push, verdict_ok, credit_return, port_send;
  pkt_word_t   word_in;
  gmii_tx_t    gmii;
  logic [31:0] lfsr = 32'h6f25;
  logic [7:0]  exp_bytes[$];      // expected frames back to back
  int          exp_len[$];
  logic [7:0]  burst[$];          // bytes of the txen burst in progress
  int errors = 0, checks = 0, errors_at_start = 0, tests_run = 0, tests_ok = 0;
  int words_pushed = 0, words_returned = 0, good_pkts = 0, frames_seen = 0;
  int sends_seen = 0, idle_run = 0, assert_fails = 0;
  logic prev_txen = 1'b0, prev_send = 1'b0, seen_frame = 1'b0;

  tb_clock_gen u_clk (.gmii_txclk(gmii_txclk), .reset(reset));

  gmii_tx_top DUT (
    .gmii_txclk (gmii_txclk), .reset (reset),
    .word_push (word_push), .word_in (word_in),
    .verdict_push (verdict_push), .verdict_ok (verdict_ok),
    .credit_return (credit_return), .gmii (gmii), .port_send (port_send)
  );

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
        lfsr = lfsr ^ 32'h8020_0003;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic int credits_held();
    return `GMII_WORD_DEPTH - (words_pushed - words_returned);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic drive_word(input pkt_word_t w);
    @(posedge gmii_txclk);
    while (credits_held() <= 0)   // stall while out of credits
    begin
      word_push <= 1'b0;
      @(posedge gmii_txclk);
    end
    word_push <= 1'b1;
    word_in   <= w;
    words_pushed++;
  endtask

  // builds the words and the expected frame of a good well-formed packet
  task automatic send_packet(input int nwords, input logic [3:0] last, input logic ok,
                             input logic malformed);
    pkt_word_t  w;
    logic [7:0] b;
    logic       keep;
    keep = ok && !malformed;
    if (keep)
    begin
      repeat (`GMII_PREAMBLE_LEN) exp_bytes.push_back(`GMII_PREAMBLE_BYTE);
      exp_bytes.push_back(`GMII_SFD_BYTE);
      exp_len.push_back(8 + 16 * (nwords - 1) + last + 1);
      good_pkts++;
    end
    for (int k = 0; k < nwords; k++)
    begin
      w = '0;
      if (k == nwords - 1)
      begin
        w.kind     = WORD_TAIL;
        w.last_idx = last;
      end
      else if (k == 0)
        w.kind = malformed ? WORD_MID : WORD_HEAD;
      else
        w.kind = WORD_MID;
      for (int j = 0; j < `GMII_WORD_BYTES; j++)
      begin
        b = 8'(take_bits(8));
        w.data[(`GMII_WORD_BYTES - 1 - j) * 8 +: 8] = b;   // byte 0 goes out first
        if (keep && ((k < nwords - 1) || (j <= last)))
          exp_bytes.push_back(b);
      end
      drive_word(w);
    end
    @(posedge gmii_txclk);
    word_push    <= 1'b0;
    verdict_push <= 1'b1;
    verdict_ok   <= ok;
    @(posedge gmii_txclk);
    verdict_push <= 1'b0;
  endtask

  task automatic compare_frame();
    int len;
    logic [7:0] e;
    if (exp_len.size() == 0)
    begin
      errors++;
      $display("A frame of %0d bytes was sent with no good packet waiting for it",
               burst.size());
    end
    else
    begin
      len = exp_len.pop_front();
      check_value("frame length", burst.size(), len);
      for (int i = 0; i < len; i++)
      begin
        e = exp_bytes.pop_front();
        if (i < burst.size())
          check_value($sformatf("gmii.txd byte %0d", i), burst[i], e);
      end
    end
    burst.delete();
    frames_seen++;
  endtask

  // monitor samples DUT outputs on the rising edge
  always @(posedge gmii_txclk)
  begin
    if (reset === 1'b1)
    begin
      if (credit_return)
        words_returned++;
      if (port_send)
        sends_seen++;
      if (gmii.txen)
      begin
        if (!prev_txen)
        begin
          check_value("port_send before txen", prev_send, 1);
          if (seen_frame && (idle_run < `GMII_IFG_CYCLES))
          begin
            errors++;
            $display("Only %0d idle cycles before the frame starting at %0t",
                     idle_run, $time);
          end
        end
        burst.push_back(gmii.txd);
      end
      else
      begin
        if (prev_txen)
        begin
          compare_frame();
          seen_frame = 1'b1;
          idle_run   = 0;
        end
        idle_run++;
      end
      prev_txen = gmii.txen;
      prev_send = port_send;
    end
  end

  task automatic wait_drain();
    while ((frames_seen < good_pkts) || (words_returned < words_pushed))
      @(posedge gmii_txclk);
    repeat (`GMII_IFG_CYCLES + 4) @(posedge gmii_txclk);
  endtask

  task automatic end_test(input string name);
    errors += DUT.u_asserts.fail_count - assert_fails;   // failures of the bound checks
    assert_fails = DUT.u_asserts.fail_count;
    tests_run++;
    if (errors == errors_at_start)
      tests_ok++;
    $display("test %-16s %s, %0d errors", name,
             (errors == errors_at_start) ? "passed" : "failed", errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog: the run timed out at %0t before all traffic drained", $time);
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    word_push    = 1'b0;
    word_in      = '0;
    verdict_push = 1'b0;
    verdict_ok   = 1'b0;
    @(posedge reset);
    repeat (20)
    begin
      @(posedge gmii_txclk);
      check_value("gmii.txen", gmii.txen, 0);
      check_value("port_send", port_send, 0);
      check_value("credit_return", credit_return, 0);
    end
    end_test("reset_quiet");

    send_packet(2, 4'd9, 1'b1, 1'b0);
    wait_drain();
    end_test("single_frame");

    send_packet(2, 4'd3, 1'b1, 1'b0);
    send_packet(3, 4'd15, 1'b0, 1'b0);   // bad verdict
    send_packet(2, 4'd0, 1'b1, 1'b1);    // no head word
    send_packet(3, 4'd7, 1'b1, 1'b0);
    wait_drain();
    check_value("port_send count", sends_seen, good_pkts);
    end_test("dropped_packets");

    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      send_packet(2 + take_bits(2), 4'(take_bits(4)), take_bits(3) != 0,
                  take_bits(4) == 0);
      repeat (take_bits(2)) @(posedge gmii_txclk);
    end
    wait_drain();
    end_test("random_traffic");

    check_value("credits held", credits_held(), `GMII_WORD_DEPTH);
    check_value("credit_return count", words_returned, words_pushed);
    check_value("port_send count", sends_seen, good_pkts);
    check_value("frames left in model", exp_len.size(), 0);
    end_test("credit_balance");

    $display("%0d of %0d tests passed, %0d checks, %0d errors",
             tests_ok, tests_run, checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- gmii_tx.f
+incdir+design
design/gmii_tx_pkg.sv
design/pkt_sync_fifo.sv
design/frame_serializer.sv
design/gmii_tx_top.sv
test/tb_clock_gen.sv
test/gmii_tx_asserts.sv
test/gmii_tx_tb.sv

//--- Bender.yml
package:
  name: gmii_tx

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/gmii_tx_pkg.sv
      - design/pkt_sync_fifo.sv
      - design/frame_serializer.sv
      - design/gmii_tx_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_clock_gen.sv
      - test/gmii_tx_asserts.sv
      - test/gmii_tx_tb.sv
